// File: hdl/codec_pkg.sv
package codec_pkg;

	// code geometry, check bits low and data bits high
	localparam int data_w = 7;
	localparam int chk_w = 4;
	localparam int cw_w = data_w + chk_w;
	localparam int data_lsb = chk_w; // first data position in the codeword
	localparam int cnt_w = 8;

	typedef logic [data_w-1:0] data_t;
	typedef logic [cw_w-1:0] codeword_t;
	typedef logic [chk_w-1:0] syndrome_t;
	typedef logic [chk_w-1:0] col_t;
	typedef logic [cnt_w-1:0] count_t;

	// one column of the check matrix per codeword position
	// data columns are distinct and of weight two or more, so every single error has its own syndrome
	localparam col_t h_cols [cw_w] = '{
		4'b0001, // position 0, check bit 0
		4'b0010, // position 1, check bit 1
		4'b0100, // position 2, check bit 2
		4'b1000, // position 3, check bit 3
		4'b0011, // data bit 0
		4'b0101,
		4'b0110,
		4'b0111,
		4'b1001,
		4'b1010,
		4'b1011  // data bit 6
	};

	typedef struct packed {
		count_t words;
		count_t corrected;
		count_t uncorrectable;
	} frame_stats_t;

	typedef struct packed {
		logic corrected;
		logic uncorrectable;
	} dec_flags_t;

	// xor of the columns of all set bits, which is the parity of each check row
	function automatic syndrome_t syndrome_of(codeword_t cw);
		syndrome_t s;
		s = '0;
		for (int p = 0; p < cw_w; p++)
		begin
			if (cw[p])
				s = s ^ h_cols[p];
		end
		return s;
	endfunction

endpackage

// File: hdl/hamming_encoder.sv
`timescale 1ns/1ps

module hamming_encoder (
	input  logic               clk,
	input  logic               rst,
	input  logic               tx_valid,
	input  codec_pkg::data_t   tx_data,
	output logic               cw_valid,
	output codec_pkg::codeword_t cw_out
);

	codec_pkg::codeword_t data_only;
	codec_pkg::syndrome_t check;
	codec_pkg::codeword_t cw_next;

	// with the check bits at zero the syndrome of the word is exactly the check bits it needs
	assign data_only = {tx_data, codec_pkg::syndrome_t'(0)};
	assign check = codec_pkg::syndrome_of(data_only);
	assign cw_next = {tx_data, check};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cw_valid <= 1'b0;
		end
		else
		begin
			cw_valid <= tx_valid; // one cycle latency, strobe for strobe
		end
	end

	// codeword holds its value between strobes
	always_ff @(posedge clk)
	begin
		if (tx_valid)
		begin
			cw_out <= cw_next;
		end
	end

endmodule

// File: hdl/syndrome_decoder.sv
`timescale 1ns/1ps

module syndrome_decoder (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 rx_valid,
	input  codec_pkg::codeword_t rx_cw,
	output logic                 out_valid,
	output codec_pkg::data_t     data_out,
	output codec_pkg::dec_flags_t flags
);

	// stage 1 registers
	logic                 s1_valid;
	codec_pkg::syndrome_t s1_syn;
	codec_pkg::codeword_t s1_cw;

	// stage 2 combinational correction
	logic                 hit;
	logic                 syn_nonzero;
	codec_pkg::codeword_t flip;
	codec_pkg::codeword_t fixed_cw;
	codec_pkg::dec_flags_t flags_next;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			s1_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= rx_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rx_valid)
		begin
			s1_syn <= codec_pkg::syndrome_of(rx_cw);
			s1_cw <= rx_cw;
		end
	end

	// look the syndrome up in the column table
	// zero is not a column, so a clean word never gets a flip
	always_comb
	begin
		hit = 1'b0;
		flip = '0;
		for (int p = 0; p < codec_pkg::cw_w; p++)
		begin
			if (s1_syn == codec_pkg::h_cols[p])
			begin
				hit = 1'b1;
				flip[p] = 1'b1;
			end
		end
	end

	assign syn_nonzero = (s1_syn != '0);
	assign fixed_cw = s1_cw ^ flip; // at most one bit changes

	always_comb
	begin
		flags_next.corrected = syn_nonzero && hit;
		flags_next.uncorrectable = syn_nonzero && !hit; // word passes through untouched
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (s1_valid)
		begin
			data_out <= fixed_cw[codec_pkg::cw_w-1:codec_pkg::data_lsb];
			flags <= flags_next;
		end
	end

endmodule

// File: hdl/frame_ctrl.sv
`timescale 1ns/1ps

module frame_ctrl #(
	parameter int FRAME_WORDS = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic word_valid,
	output logic last_word,
	output logic frame_done
);

	typedef enum logic [1:0] {
		idle,
		in_frame,
		report
	} state_t;

	localparam codec_pkg::count_t last_pos = codec_pkg::count_t'(FRAME_WORDS - 1);

	state_t            state;
	state_t            state_next;
	codec_pkg::count_t pos;      // index of the next word within the frame
	codec_pkg::count_t pos_next;

	// marks the word that closes the frame in the same cycle it is seen
	assign last_word = word_valid && (pos == last_pos);

	always_comb
	begin
		state_next = state;
		pos_next = pos;
		case (state)
			idle, in_frame, report:
			begin
				if (word_valid)
				begin
					if (last_word)
					begin
						state_next = report;
						pos_next = '0;
					end
					else
					begin
						state_next = in_frame;
						pos_next = pos + 1'b1;
					end
				end
				else if (state == report)
				begin
					state_next = idle; // report lasts one cycle
				end
			end
			default:
			begin
				state_next = idle;
				pos_next = '0;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= idle;
			pos <= '0;
			frame_done <= 1'b0;
		end
		else
		begin
			state <= state_next;
			pos <= pos_next;
			frame_done <= (state_next == report);
		end
	end

endmodule

// File: hdl/error_counter.sv
`timescale 1ns/1ps

module error_counter #(
	parameter int FRAME_WORDS = 8
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  word_valid,
	input  codec_pkg::dec_flags_t flags,
	input  logic                  last_word,
	output codec_pkg::frame_stats_t stats
);

	localparam codec_pkg::count_t max_words = codec_pkg::count_t'(FRAME_WORDS);

	codec_pkg::frame_stats_t acc;   // running counts of the open frame
	codec_pkg::frame_stats_t total; // counts including the current word
	logic                    at_max;

	// the word count never runs past a full frame
	assign at_max = (acc.words >= max_words);

	always_comb
	begin
		total = acc;
		if (word_valid)
		begin
			if (!at_max)
				total.words = acc.words + 1'b1;
			total.corrected = acc.corrected + codec_pkg::count_t'(flags.corrected);
			total.uncorrectable = acc.uncorrectable + codec_pkg::count_t'(flags.uncorrectable);
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			acc <= '0;
			stats <= '0;
		end
		else if (word_valid && last_word)
		begin
			stats <= total; // visible on the frame_done cycle
			acc <= '0;
		end
		else
		begin
			acc <= total;
		end
	end

endmodule

// File: hdl/hamming_link.sv
`timescale 1ns/1ps

module hamming_link #(
	parameter int FRAME_WORDS = 8
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    tx_valid,
	input  codec_pkg::data_t        tx_data,
	output logic                    cw_valid,
	output codec_pkg::codeword_t    cw_out,
	input  logic                    rx_valid,
	input  codec_pkg::codeword_t    rx_cw,
	output logic                    out_valid,
	output codec_pkg::data_t        data_out,
	output codec_pkg::dec_flags_t   flags,
	output logic                    frame_done,
	output codec_pkg::frame_stats_t stats
);

	logic last_word;

	hamming_encoder u_encoder (
		.clk      (clk),
		.rst      (rst),
		.tx_valid (tx_valid),
		.tx_data  (tx_data),
		.cw_valid (cw_valid),
		.cw_out   (cw_out)
	);

	syndrome_decoder u_decoder (
		.clk       (clk),
		.rst       (rst),
		.rx_valid  (rx_valid),
		.rx_cw     (rx_cw),
		.out_valid (out_valid),
		.data_out  (data_out),
		.flags     (flags)
	);

	// both frame blocks watch the decoder output
	frame_ctrl #(
		.FRAME_WORDS (FRAME_WORDS)
	) u_frame_ctrl (
		.clk        (clk),
		.rst        (rst),
		.word_valid (out_valid),
		.last_word  (last_word),
		.frame_done (frame_done)
	);

	error_counter #(
		.FRAME_WORDS (FRAME_WORDS)
	) u_error_counter (
		.clk        (clk),
		.rst        (rst),
		.word_valid (out_valid),
		.flags      (flags),
		.last_word  (last_word),
		.stats      (stats)
	);

endmodule

// File: sim/hamming_link_props.sv
`timescale 1ns/1ps

module hamming_link_props #(
	parameter int FRAME_WORDS = 8
) (
	input logic                    clk,
	input logic                    rst,
	input logic                    tx_valid,
	input logic                    cw_valid,
	input logic                    rx_valid,
	input logic                    out_valid,
	input logic                    last_word,
	input logic                    frame_done,
	input codec_pkg::frame_stats_t stats
);

	// reset clears every strobe and the report on the following edge
	reset_state: assert property (@(posedge clk)
		rst |=> (!cw_valid && !out_valid && !frame_done && stats == '0))
		else $error("outputs not cleared after reset");

	enc_latency: assert property (@(posedge clk) disable iff (rst)
		cw_valid == $past(tx_valid))
		else $error("cw_valid does not follow tx_valid by one cycle");

	dec_latency: assert property (@(posedge clk) disable iff (rst)
		out_valid == $past(rx_valid, 2))
		else $error("out_valid does not follow rx_valid by two cycles");

	done_timing: assert property (@(posedge clk) disable iff (rst)
		frame_done == $past(last_word))
		else $error("frame_done not one cycle after the last word");

	// a full frame always reports exactly FRAME_WORDS words
	done_words: assert property (@(posedge clk) disable iff (rst)
		frame_done |-> (stats.words == codec_pkg::count_t'(FRAME_WORDS)))
		else $error("frame report has the wrong word count");

endmodule

bind hamming_link hamming_link_props #(
	.FRAME_WORDS (FRAME_WORDS)
) u_props (
	.clk        (clk),
	.rst        (rst),
	.tx_valid   (tx_valid),
	.cw_valid   (cw_valid),
	.rx_valid   (rx_valid),
	.out_valid  (out_valid),
	.last_word  (last_word),
	.frame_done (frame_done),
	.stats      (stats)
);

// File: sim/tb_hamming_link.sv
`timescale 1ns/1ps

module tb_hamming_link;

	localparam int FRAME_WORDS = 8;
	localparam int NUM_FRAMES = 8;
	localparam int TOTAL_WORDS = NUM_FRAMES * FRAME_WORDS;
	localparam int WATCHDOG_CYCLES = 4 * NUM_FRAMES * FRAME_WORDS + 100;

	typedef struct packed {
		codec_pkg::data_t data;
		int               cycle;
	} tx_item_t;

	typedef struct packed {
		codec_pkg::data_t      data;
		codec_pkg::dec_flags_t flags;
		int                    cycle; // cycle on which out_valid is due
	} rx_item_t;

	logic                    clk = 1'b0;
	logic                    rst;
	logic                    tx_valid;
	codec_pkg::data_t        tx_data;
	logic                    cw_valid;
	codec_pkg::codeword_t    cw_out;
	logic                    rx_valid;
	codec_pkg::codeword_t    rx_cw;
	logic                    out_valid;
	codec_pkg::data_t        data_out;
	codec_pkg::dec_flags_t   flags;
	logic                    frame_done;
	codec_pkg::frame_stats_t stats;

	int                      cycle = 0;
	tx_item_t                tx_q[$];
	rx_item_t                exp_q[$];
	codec_pkg::codeword_t    sent_cw[$];
	codec_pkg::frame_stats_t model_acc;
	codec_pkg::frame_stats_t done_stats;
	logic                    done_pending;
	int                      frames_seen;

	hamming_link #(
		.FRAME_WORDS (FRAME_WORDS)
	) UUT (
		.clk        (clk),
		.rst        (rst),
		.tx_valid   (tx_valid),
		.tx_data    (tx_data),
		.cw_valid   (cw_valid),
		.cw_out     (cw_out),
		.rx_valid   (rx_valid),
		.rx_cw      (rx_cw),
		.out_valid  (out_valid),
		.data_out   (data_out),
		.flags      (flags),
		.frame_done (frame_done),
		.stats      (stats)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	// check bit k is the parity of the data bits whose column has bit k set
	function automatic codec_pkg::codeword_t encode_word(codec_pkg::data_t d);
		codec_pkg::syndrome_t chk;
		chk = '0;
		for (int k = 0; k < 4; k++)
			for (int j = 0; j < 7; j++)
				if (codec_pkg::h_cols[j + 4][k])
					chk[k] = chk[k] ^ d[j];
		return {d, chk};
	endfunction

	function automatic rx_item_t predict(codec_pkg::codeword_t rcv, int at_cycle);
		rx_item_t e;
		codec_pkg::syndrome_t s;
		codec_pkg::codeword_t fixed;
		s = '0;
		for (int k = 0; k < 4; k++)
			for (int p = 0; p < 11; p++)
				if (codec_pkg::h_cols[p][k])
					s[k] = s[k] ^ rcv[p];
		fixed = rcv;
		e.flags = '0;
		if (s != '0)
		begin
			e.flags.uncorrectable = 1'b1; // unless some column matches below
			for (int p = 0; p < 11; p++)
				if (codec_pkg::h_cols[p] == s)
				begin
					fixed[p] = ~rcv[p];
					e.flags.corrected = 1'b1;
					e.flags.uncorrectable = 1'b0;
				end
		end
		e.data = fixed[10:4];
		e.cycle = at_cycle + 2;
		return e;
	endfunction

	// the first 22 words walk a single error over every position twice
	function automatic codec_pkg::codeword_t corrupt(codec_pkg::codeword_t cw, int idx);
		int p1;
		int p2;
		int mode;
		p1 = int'($urandom_range(0, 10));
		p2 = (p1 + int'($urandom_range(1, 10))) % 11;
		mode = (idx < 22) ? 1 : idx % 4;
		if (idx < 22)
			p1 = idx % 11;
		case (mode)
			0: return cw;
			1: return cw ^ (11'd1 << p1);
			2: return cw ^ (11'd1 << p1) ^ (11'd1 << p2);
			default: return cw ^ codec_pkg::codeword_t'(4'hc + $urandom_range(0, 3)); // 12 to 15 match no column
		endcase
	endfunction

	task automatic check_codeword();
		tx_item_t t;
		if (tx_q.size() == 0)
			abort_run("cw_valid was raised with no tx word pending");
		else
		begin
			t = tx_q.pop_front();
			assert (cycle == t.cycle + 1)
				else abort_run($sformatf("ERROR at %0t: cw_valid on the wrong cycle", $time));
			assert (cw_out == encode_word(t.data))
				else abort_run($sformatf("ERROR at %0t: cw_out %h, expected %h",
					$time, cw_out, encode_word(t.data)));
			sent_cw.push_back(cw_out);
		end
	endtask

	task automatic check_decoded();
		rx_item_t e;
		if (exp_q.size() == 0)
			abort_run("out_valid was raised with no rx word pending");
		else
		begin
			e = exp_q.pop_front();
			assert (cycle == e.cycle)
				else abort_run($sformatf("ERROR at %0t: out_valid on the wrong cycle", $time));
			assert (data_out == e.data && flags == e.flags)
				else abort_run($sformatf("ERROR at %0t: data %h flags %b, expected %h %b",
					$time, data_out, flags, e.data, e.flags));
			model_acc.words = model_acc.words + 8'd1;
			if (e.flags.corrected)
				model_acc.corrected = model_acc.corrected + 8'd1;
			if (e.flags.uncorrectable)
				model_acc.uncorrectable = model_acc.uncorrectable + 8'd1;
			if (model_acc.words == FRAME_WORDS)
			begin
				done_pending = 1'b1; // report is due on the next cycle
				done_stats = model_acc;
				model_acc = '0;
			end
		end
	endtask

	task automatic check_frame_done();
		assert (frame_done == done_pending)
			else abort_run($sformatf("ERROR at %0t: frame_done %b, expected %b",
				$time, frame_done, done_pending));
		if (done_pending)
		begin
			assert (stats == done_stats)
				else abort_run($sformatf("ERROR at %0t: stats %0d/%0d/%0d, expected %0d/%0d/%0d",
					$time, stats.words, stats.corrected, stats.uncorrectable,
					done_stats.words, done_stats.corrected, done_stats.uncorrectable));
			frames_seen++;
		end
		done_pending = 1'b0;
	endtask

	// outputs change on the rising edge and are sampled on the falling one
	always @(negedge clk)
	begin
		if (!rst)
		begin
			check_frame_done();
			if (out_valid)
				check_decoded();
			if (cw_valid)
				check_codeword();
		end
	end

	task automatic send_tx_words();
		tx_item_t t;
		for (int i = 0; i < TOTAL_WORDS; i++)
		begin
			t.data = codec_pkg::data_t'($urandom);
			t.cycle = cycle;
			tx_valid = 1'b1;
			tx_data = t.data;
			tx_q.push_back(t);
			@(posedge clk);
			#1;
			tx_valid = 1'b0;
			repeat ($urandom_range(0, 1))
			begin
				@(posedge clk);
				#1;
			end
		end
	endtask

	task automatic send_rx_words();
		codec_pkg::codeword_t bad;
		for (int i = 0; i < TOTAL_WORDS; i++)
		begin
			// odd frames have idle gaps, but each frame follows the previous one directly
			if ((i / FRAME_WORDS) % 2 == 1 && i % FRAME_WORDS != 0)
			begin
				repeat ($urandom_range(0, 2))
				begin
					@(posedge clk);
					#1;
				end
			end
			bad = corrupt(sent_cw[i], i);
			rx_valid = 1'b1;
			rx_cw = bad;
			exp_q.push_back(predict(bad, cycle));
			@(posedge clk);
			#1;
			rx_valid = 1'b0;
		end
	endtask

	initial
	begin
		rst = 1'b1;
		tx_valid = 1'b0;
		tx_data = '0;
		rx_valid = 1'b0;
		rx_cw = '0;
		model_acc = '0;
		done_stats = '0;
		done_pending = 1'b0;
		frames_seen = 0;
		void'($urandom(32'hbe400473));
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		send_tx_words();
		while (sent_cw.size() < TOTAL_WORDS)
			@(posedge clk);
		#1;
		send_rx_words();
		while (frames_seen < NUM_FRAMES)
			@(posedge clk);
		repeat (4) @(posedge clk);
		$display("STATUS: PASS");
		$finish;
	end

	// a word needs only a few cycles on each side, so four per word is plenty
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run($sformatf("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES));
	end

endmodule

// File: files.f
hdl/codec_pkg.sv
hdl/hamming_encoder.sv
hdl/syndrome_decoder.sv
hdl/frame_ctrl.sv
hdl/error_counter.sv
hdl/hamming_link.sv
sim/hamming_link_props.sv
sim/tb_hamming_link.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_hamming_link \
	-f files.f -o tb_sim > build.log 2>&1 &&
	./obj_dir/tb_sim > sim.log 2>&1 ||
	echo "build or simulation ended with an error, see build.log and sim.log"
grep -q "STATUS: PASS" sim.log && echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }
